/* include/rv_core_defines.svh */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

`define XLEN        32
`define NUM_REGS    32
`define IMEM_DEPTH  64              // instruction words
`define DMEM_DEPTH  32              // data words

// loader framing bytes
`define LOAD_START_BYTE 8'hFE
`define LOAD_END_BYTE   8'hFF

`define ALU_ADD 2'd0
`define ALU_SUB 2'd1
`define ALU_AND 2'd2
`define ALU_OR  2'd3

`define OPC_RTYPE  7'b0110011      // add, sub, and, or
`define OPC_ITYPE  7'b0010011      // addi
`define OPC_LOAD   7'b0000011      // lw
`define OPC_STORE  7'b0100011      // sw
`define OPC_BRANCH 7'b1100011      // beq

`endif

/* source/rv_core_pkg.sv */
`include "rv_core_defines.svh"

package rv_core_pkg;

    typedef logic [`XLEN-1:0]                word_t;
    typedef logic [7:0]                      byte_t;
    typedef logic [$clog2(`NUM_REGS)-1:0]    reg_addr_t;
    typedef logic [$clog2(`IMEM_DEPTH)-1:0]  imem_addr_t;
    typedef logic [$clog2(`DMEM_DEPTH)-1:0]  dmem_addr_t;
    typedef logic [1:0]                      alu_op_t;

    // operand source in EX
    typedef enum logic [1:0] {
        FWD_RF,                     // value read in decode
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_t;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_LOADING,
        LD_RUNNING                  // held until reset
    } loader_state_t;

endpackage

/* source/instr_loader.sv */
`include "rv_core_defines.svh"

module instr_loader (
    input  logic                    clk_i,
    input  logic                    reset,
    input  rv_core_pkg::byte_t      instr_i,
    output logic                    imem_we_o,
    output rv_core_pkg::imem_addr_t imem_waddr_o,
    output rv_core_pkg::word_t      imem_wdata_o,
    output logic                    run_o
);
    import rv_core_pkg::*;

    loader_state_t state_q;
    logic [1:0]    byte_cnt_q;              // bytes of current word so far
    logic [23:0]   shift_q;                 // three older bytes in lsb-first order
    imem_addr_t    word_idx_q;
    logic          data_byte;

    assign data_byte    = (state_q == LD_LOADING) && (instr_i != `LOAD_END_BYTE);
    assign imem_we_o    = data_byte && (byte_cnt_q == 2'd3);
    assign imem_waddr_o = word_idx_q;
    assign imem_wdata_o = {instr_i, shift_q};     // fourth byte is the msb
    assign run_o        = (state_q == LD_RUNNING);

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            state_q    <= LD_IDLE;
            byte_cnt_q <= 2'd0;
            word_idx_q <= '0;
        end else begin
            case (state_q)
                LD_IDLE: begin
                    if (instr_i == `LOAD_START_BYTE) begin
                        state_q <= LD_LOADING;
                    end
                end
                LD_LOADING: begin
                    if (instr_i == `LOAD_END_BYTE) begin
                        state_q <= LD_RUNNING;
                    end else begin
                        byte_cnt_q <= byte_cnt_q + 2'd1;    // wraps after byte 3
                        if (byte_cnt_q == 2'd3) begin
                            word_idx_q <= word_idx_q + 1'b1;
                        end
                    end
                end
                default: state_q <= state_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_byte) begin
            shift_q <= {instr_i, shift_q[23:8]};
        end
    end

endmodule

/* source/fetch_stage.sv */
`include "rv_core_defines.svh"

module fetch_stage (
    input  logic                    clk_i,
    input  logic                    reset,
    input  logic                    run_i,
    input  logic                    imem_we_i,
    input  rv_core_pkg::imem_addr_t imem_waddr_i,
    input  rv_core_pkg::word_t      imem_wdata_i,
    input  logic                    stall_i,
    input  logic                    branch_taken_i,
    input  rv_core_pkg::word_t      branch_target_i,
    output rv_core_pkg::word_t      if_pc_o,
    output rv_core_pkg::word_t      if_instr_o
);
    import rv_core_pkg::*;

    localparam word_t NOP = 32'h0000_0013;     // addi x0,x0,0

    word_t      imem [`IMEM_DEPTH];
    word_t      pc_q;
    word_t      pc_next;
    imem_addr_t fetch_idx;

    assign fetch_idx = imem_addr_t'(pc_q >> 2);
    assign pc_next   = branch_taken_i ? branch_target_i : pc_q + 32'd4;

    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem[imem_waddr_i] <= imem_wdata_i;
        end
    end

    // pc and IF/ID
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            pc_q       <= '0;
            if_pc_o    <= '0;
            if_instr_o <= NOP;
        end else if (run_i) begin
            if (branch_taken_i || !stall_i) begin
                pc_q <= pc_next;
            end
            if (branch_taken_i) begin
                if_instr_o <= NOP;                 // drop wrong-path fetch
            end else if (!stall_i) begin
                if_pc_o    <= pc_q;
                if_instr_o <= imem[fetch_idx];
            end
        end
    end

endmodule

/* source/decode_stage.sv */
`include "rv_core_defines.svh"

module decode_stage (
    input  logic                   clk_i,
    input  logic                   reset,
    input  logic                   run_i,
    input  rv_core_pkg::word_t     if_pc_i,
    input  rv_core_pkg::word_t     if_instr_i,
    input  logic                   ex_mem_read_i,
    input  rv_core_pkg::reg_addr_t wb_rd_i,
    input  logic                   wb_reg_write_i,
    input  rv_core_pkg::word_t     wb_data_i,
    input  rv_core_pkg::reg_addr_t dbg_addr_i,
    output logic                   stall_o,
    output logic                   branch_taken_o,
    output rv_core_pkg::word_t     branch_target_o,
    output rv_core_pkg::reg_addr_t ex_rs1_o, ex_rs2_o, ex_rd_o,
    output rv_core_pkg::word_t     ex_rs1_data_o, ex_rs2_data_o, ex_imm_o,
    output rv_core_pkg::alu_op_t   ex_alu_op_o,
    output logic                   ex_alu_src_o, ex_reg_write_o, ex_mem_read_o,
    output logic                   ex_mem_write_o, ex_mem_to_reg_o,
    output rv_core_pkg::word_t     dbg_reg_o
);
    import rv_core_pkg::*;

    word_t      regs [`NUM_REGS];
    logic [6:0] opcode;
    reg_addr_t  rs1, rs2, rd;
    word_t      rs1_data, rs2_data;
    word_t      imm_i, imm_s, imm_b;
    alu_op_t    alu_op;
    logic       alu_src, reg_write, mem_read, mem_write, mem_to_reg;
    logic       uses_rs2, is_beq;

    // read with write-first bypass and x0 tied to zero
    function automatic word_t rf_read(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_reg_write_i && (wb_rd_i == addr)) begin
            return wb_data_i;
        end
        return regs[addr];
    endfunction

    assign opcode = if_instr_i[6:0];
    assign rd     = if_instr_i[11:7];
    assign rs1    = if_instr_i[19:15];
    assign rs2    = if_instr_i[24:20];
    assign imm_i  = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    assign imm_s  = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
    assign imm_b  = {{20{if_instr_i[31]}}, if_instr_i[7], if_instr_i[30:25],
                     if_instr_i[11:8], 1'b0};

    always_comb begin
        rs1_data  = rf_read(rs1);
        rs2_data  = rf_read(rs2);
        dbg_reg_o = rf_read(dbg_addr_i);
    end

    always_comb begin
        alu_op     = `ALU_ADD;
        alu_src    = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        uses_rs2   = 1'b0;
        is_beq     = 1'b0;
        case (opcode)
            `OPC_RTYPE: begin
                reg_write = 1'b1;
                uses_rs2  = 1'b1;
                case (if_instr_i[14:12])
                    3'b111:  alu_op = `ALU_AND;
                    3'b110:  alu_op = `ALU_OR;
                    default: alu_op = if_instr_i[30] ? `ALU_SUB : `ALU_ADD;
                endcase
            end
            `OPC_ITYPE: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            `OPC_LOAD: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
            end
            `OPC_STORE: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                uses_rs2  = 1'b1;
            end
            `OPC_BRANCH: begin
                uses_rs2 = 1'b1;
                is_beq   = (if_instr_i[14:12] == 3'b000);
            end
            default: ;
        endcase
    end

    // load in EX feeding this instruction
    assign stall_o = ex_mem_read_i && (ex_rd_o != '0) &&
                     ((ex_rd_o == rs1) || (uses_rs2 && (ex_rd_o == rs2)));

    assign branch_taken_o  = is_beq && (rs1_data == rs2_data) && !stall_o;
    assign branch_target_o = if_pc_i + imm_b;

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_reg_write_i && (wb_rd_i != '0)) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // ID/EX control with a bubble on stall
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            ex_rs1_o        <= '0;
            ex_rs2_o        <= '0;
            ex_rd_o         <= '0;
            ex_alu_op_o     <= `ALU_ADD;
            ex_alu_src_o    <= 1'b0;
            ex_reg_write_o  <= 1'b0;
            ex_mem_read_o   <= 1'b0;
            ex_mem_write_o  <= 1'b0;
            ex_mem_to_reg_o <= 1'b0;
        end else if (run_i) begin
            ex_rs1_o        <= rs1;
            ex_rs2_o        <= rs2;
            ex_rd_o         <= rd;
            ex_alu_op_o     <= alu_op;
            ex_alu_src_o    <= alu_src && !stall_o;
            ex_reg_write_o  <= reg_write && !stall_o;
            ex_mem_read_o   <= mem_read && !stall_o;
            ex_mem_write_o  <= mem_write && !stall_o;
            ex_mem_to_reg_o <= mem_to_reg && !stall_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (run_i) begin
            ex_rs1_data_o <= rs1_data;
            ex_rs2_data_o <= rs2_data;
            ex_imm_o      <= (opcode == `OPC_STORE) ? imm_s : imm_i;
        end
    end

endmodule

/* source/execute_stage.sv */
`include "rv_core_defines.svh"

module execute_stage (
    input  logic                   clk_i,
    input  logic                   reset,
    input  logic                   run_i,
    input  rv_core_pkg::reg_addr_t ex_rs1_i, ex_rs2_i, ex_rd_i,
    input  rv_core_pkg::word_t     ex_rs1_data_i, ex_rs2_data_i, ex_imm_i,
    input  rv_core_pkg::alu_op_t   ex_alu_op_i,
    input  logic                   ex_alu_src_i, ex_reg_write_i, ex_mem_read_i,
    input  logic                   ex_mem_write_i, ex_mem_to_reg_i,
    input  rv_core_pkg::reg_addr_t wb_rd_i,
    input  logic                   wb_reg_write_i,
    input  rv_core_pkg::word_t     wb_data_i,
    output rv_core_pkg::word_t     mem_alu_result_o,
    output rv_core_pkg::word_t     mem_store_data_o,
    output rv_core_pkg::reg_addr_t mem_rd_o,
    output logic                   mem_reg_write_o, mem_mem_read_o,
    output logic                   mem_mem_write_o, mem_mem_to_reg_o
);
    import rv_core_pkg::*;

    fwd_sel_t fwd_a, fwd_b;
    word_t    op_a, op_b, rs2_val, alu_result;

    // newest producer wins
    function automatic fwd_sel_t fwd_select(reg_addr_t rs);
        if (rs == '0) begin
            return FWD_RF;
        end
        if (mem_reg_write_o && (mem_rd_o == rs)) begin
            return FWD_EXMEM;
        end
        if (wb_reg_write_i && (wb_rd_i == rs)) begin
            return FWD_MEMWB;
        end
        return FWD_RF;
    endfunction

    function automatic word_t fwd_value(fwd_sel_t sel, word_t rf_data);
        case (sel)
            FWD_EXMEM: return mem_alu_result_o;
            FWD_MEMWB: return wb_data_i;
            default:   return rf_data;
        endcase
    endfunction

    always_comb begin
        fwd_a   = fwd_select(ex_rs1_i);
        fwd_b   = fwd_select(ex_rs2_i);
        op_a    = fwd_value(fwd_a, ex_rs1_data_i);
        rs2_val = fwd_value(fwd_b, ex_rs2_data_i);     // also the store data
        op_b    = ex_alu_src_i ? ex_imm_i : rs2_val;
        case (ex_alu_op_i)
            `ALU_SUB: alu_result = op_a - op_b;
            `ALU_AND: alu_result = op_a & op_b;
            `ALU_OR:  alu_result = op_a | op_b;
            default:  alu_result = op_a + op_b;        // add, address calc
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            mem_rd_o         <= '0;
            mem_reg_write_o  <= 1'b0;
            mem_mem_read_o   <= 1'b0;
            mem_mem_write_o  <= 1'b0;
            mem_mem_to_reg_o <= 1'b0;
        end else if (run_i) begin
            mem_rd_o         <= ex_rd_i;
            mem_reg_write_o  <= ex_reg_write_i;
            mem_mem_read_o   <= ex_mem_read_i;
            mem_mem_write_o  <= ex_mem_write_i;
            mem_mem_to_reg_o <= ex_mem_to_reg_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (run_i) begin
            mem_alu_result_o <= alu_result;
            mem_store_data_o <= rs2_val;
        end
    end

endmodule

/* source/memory_stage.sv */
`include "rv_core_defines.svh"

module memory_stage (
    input  logic                    clk_i,
    input  logic                    reset,
    input  logic                    run_i,
    input  rv_core_pkg::word_t      mem_alu_result_i,
    input  rv_core_pkg::word_t      mem_store_data_i,
    input  rv_core_pkg::reg_addr_t  mem_rd_i,
    input  logic                    mem_reg_write_i, mem_mem_read_i,
    input  logic                    mem_mem_write_i, mem_mem_to_reg_i,
    input  rv_core_pkg::dmem_addr_t dbg_addr_i,
    output rv_core_pkg::reg_addr_t  wb_rd_o,
    output logic                    wb_reg_write_o,
    output rv_core_pkg::word_t      wb_data_o,
    output rv_core_pkg::word_t      dbg_mem_o
);
    import rv_core_pkg::*;

    word_t      dmem [`DMEM_DEPTH];
    dmem_addr_t dmem_idx;
    word_t      load_data;
    word_t      wb_alu_result_q, wb_load_data_q;
    logic       wb_mem_to_reg_q;

    assign dmem_idx  = mem_alu_result_i[6:2];          // word addressed
    assign load_data = mem_mem_read_i ? dmem[dmem_idx] : '0;
    assign dbg_mem_o = dmem[dbg_addr_i];
    assign wb_data_o = wb_mem_to_reg_q ? wb_load_data_q : wb_alu_result_q;

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (run_i && mem_mem_write_i) begin
            dmem[dmem_idx] <= mem_store_data_i;
        end
    end

    // MEM/WB
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            wb_rd_o         <= '0;
            wb_reg_write_o  <= 1'b0;
            wb_mem_to_reg_q <= 1'b0;
        end else if (run_i) begin
            wb_rd_o         <= mem_rd_i;
            wb_reg_write_o  <= mem_reg_write_i;
            wb_mem_to_reg_q <= mem_mem_to_reg_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (run_i) begin
            wb_alu_result_q <= mem_alu_result_i;
            wb_load_data_q  <= load_data;
        end
    end

endmodule

/* source/rv_core.sv */
module rv_core (
    input  logic                   clk_i,
    input  logic                   reset,
    input  logic                   data_or_reg_i,     // 1 register, 0 data memory
    input  rv_core_pkg::byte_t     instr_i,
    input  rv_core_pkg::reg_addr_t address_i,
    input  logic [1:0]             vout_addr_i,
    output rv_core_pkg::byte_t     value_o
);
    import rv_core_pkg::*;

    logic       run, imem_we, stall, branch_taken;
    imem_addr_t imem_waddr;
    word_t      imem_wdata, if_pc, if_instr, branch_target;
    reg_addr_t  ex_rs1, ex_rs2, ex_rd, mem_rd, wb_rd;
    word_t      ex_rs1_data, ex_rs2_data, ex_imm;
    alu_op_t    ex_alu_op;
    logic       ex_alu_src, ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg;
    word_t      mem_alu_result, mem_store_data;
    logic       mem_reg_write, mem_mem_read, mem_mem_write, mem_mem_to_reg;
    logic       wb_reg_write;
    word_t      wb_data, dbg_reg, dbg_mem, readout_word;

    assign readout_word = data_or_reg_i ? dbg_reg : dbg_mem;
    assign value_o      = readout_word[{vout_addr_i, 3'b000} +: 8];   // byte 0 is lsb

    instr_loader i_instr_loader (
        .clk_i, .reset, .instr_i,
        .imem_we_o(imem_we), .imem_waddr_o(imem_waddr), .imem_wdata_o(imem_wdata),
        .run_o(run)
    );

    fetch_stage i_fetch_stage (
        .clk_i, .reset, .run_i(run),
        .imem_we_i(imem_we), .imem_waddr_i(imem_waddr), .imem_wdata_i(imem_wdata),
        .stall_i(stall), .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .if_pc_o(if_pc), .if_instr_o(if_instr)
    );

    decode_stage i_decode_stage (
        .clk_i, .reset, .run_i(run),
        .if_pc_i(if_pc), .if_instr_i(if_instr), .ex_mem_read_i(ex_mem_read),
        .wb_rd_i(wb_rd), .wb_reg_write_i(wb_reg_write), .wb_data_i(wb_data),
        .dbg_addr_i(address_i),
        .stall_o(stall), .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .ex_rs1_o(ex_rs1), .ex_rs2_o(ex_rs2), .ex_rd_o(ex_rd),
        .ex_rs1_data_o(ex_rs1_data), .ex_rs2_data_o(ex_rs2_data), .ex_imm_o(ex_imm),
        .ex_alu_op_o(ex_alu_op), .ex_alu_src_o(ex_alu_src),
        .ex_reg_write_o(ex_reg_write), .ex_mem_read_o(ex_mem_read),
        .ex_mem_write_o(ex_mem_write), .ex_mem_to_reg_o(ex_mem_to_reg),
        .dbg_reg_o(dbg_reg)
    );

    execute_stage i_execute_stage (
        .clk_i, .reset, .run_i(run),
        .ex_rs1_i(ex_rs1), .ex_rs2_i(ex_rs2), .ex_rd_i(ex_rd),
        .ex_rs1_data_i(ex_rs1_data), .ex_rs2_data_i(ex_rs2_data), .ex_imm_i(ex_imm),
        .ex_alu_op_i(ex_alu_op), .ex_alu_src_i(ex_alu_src),
        .ex_reg_write_i(ex_reg_write), .ex_mem_read_i(ex_mem_read),
        .ex_mem_write_i(ex_mem_write), .ex_mem_to_reg_i(ex_mem_to_reg),
        .wb_rd_i(wb_rd), .wb_reg_write_i(wb_reg_write), .wb_data_i(wb_data),
        .mem_alu_result_o(mem_alu_result), .mem_store_data_o(mem_store_data),
        .mem_rd_o(mem_rd), .mem_reg_write_o(mem_reg_write),
        .mem_mem_read_o(mem_mem_read), .mem_mem_write_o(mem_mem_write),
        .mem_mem_to_reg_o(mem_mem_to_reg)
    );

    memory_stage i_memory_stage (
        .clk_i, .reset, .run_i(run),
        .mem_alu_result_i(mem_alu_result), .mem_store_data_i(mem_store_data),
        .mem_rd_i(mem_rd), .mem_reg_write_i(mem_reg_write),
        .mem_mem_read_i(mem_mem_read), .mem_mem_write_i(mem_mem_write),
        .mem_mem_to_reg_i(mem_mem_to_reg),
        .dbg_addr_i(address_i),
        .wb_rd_o(wb_rd), .wb_reg_write_o(wb_reg_write), .wb_data_o(wb_data),
        .dbg_mem_o(dbg_mem)
    );

endmodule

/* sim/rv_core_tb.sv */
`include "rv_core_defines.svh"

module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_core_pkg::*;

    localparam int VERIFY_CYCLES = (`NUM_REGS + `DMEM_DEPTH) * 4;    // one cycle per byte
    localparam int TEST_CYCLES   = 8 * VERIFY_CYCLES + 7 * (9 + 100) + 300;  // loads and byte reads
    localparam int TIMEOUT_NS    = TEST_CYCLES * 20 * 2;

    logic       clk_i = 1'b0;
    logic       reset = 1'b1;
    logic       data_or_reg_i = 1'b0;
    byte_t      instr_i = 8'h00;
    reg_addr_t  address_i = '0;
    logic [1:0] vout_addr_i = 2'd0;
    byte_t      value_o;

    word_t prog[$];
    word_t model_regs [`NUM_REGS];                      // expected architectural state
    word_t model_mem [`DMEM_DEPTH];
    int    error_count = 0;
    int    check_count = 0;

    rv_core i_rv_core (
        .clk_i, .reset, .data_or_reg_i, .instr_i, .address_i, .vout_addr_i, .value_o
    );

    always #10 clk_i = ~clk_i;

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `OPC_RTYPE};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs1, reg_addr_t rs2);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    task automatic model_write(reg_addr_t rd, word_t value);
        if (rd != '0) begin
            model_regs[rd] = value;
        end
    endtask

    task automatic new_program();
        prog.delete();
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
    endtask

    task automatic emit_addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        prog.push_back(enc_i(imm, rs1, 3'b000, rd, `OPC_ITYPE));
        model_write(rd, model_regs[rs1] + {{20{imm[11]}}, imm});
    endtask

    task automatic emit_r(alu_op_t op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        word_t a;
        word_t b;
        a = model_regs[rs1];
        b = model_regs[rs2];
        case (op)
            `ALU_SUB: begin
                prog.push_back(enc_r(7'h20, rs2, rs1, 3'b000, rd));
                model_write(rd, a - b);
            end
            `ALU_AND: begin
                prog.push_back(enc_r(7'h00, rs2, rs1, 3'b111, rd));
                model_write(rd, a & b);
            end
            `ALU_OR: begin
                prog.push_back(enc_r(7'h00, rs2, rs1, 3'b110, rd));
                model_write(rd, a | b);
            end
            default: begin
                prog.push_back(enc_r(7'h00, rs2, rs1, 3'b000, rd));
                model_write(rd, a + b);
            end
        endcase
    endtask

    task automatic emit_sw(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
        word_t addr;
        addr = model_regs[rs1] + {{20{imm[11]}}, imm};
        prog.push_back(enc_s(imm, rs2, rs1));
        model_mem[addr[6:2]] = model_regs[rs2];         // word index as in the core
    endtask

    task automatic emit_lw(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        word_t addr;
        addr = model_regs[rs1] + {{20{imm[11]}}, imm};
        prog.push_back(enc_i(imm, rs1, 3'b010, rd, `OPC_LOAD));
        model_write(rd, model_mem[addr[6:2]]);
    endtask

    task automatic emit_end();
        prog.push_back(enc_b(13'd0, 5'd0, 5'd0));      // beq x0,x0,0
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        #2 reset = 1'b1;
        instr_i = 8'h00;
        repeat (8) @(posedge clk_i);
        #2 reset = 1'b0;
    endtask

    task automatic load_program();
        byte_t bt;
        @(posedge clk_i);
        #2 instr_i = `LOAD_START_BYTE;
        foreach (prog[w]) begin
            for (int b = 0; b < 4; b++) begin
                bt = prog[w][8*b +: 8];                 // lsb first
                if (bt == `LOAD_END_BYTE) begin
                    error_count++;
                    $display("program word %0d holds the end marker byte", w);
                end
                @(posedge clk_i);
                #2 instr_i = bt;
            end
        end
        @(posedge clk_i);
        #2 instr_i = `LOAD_END_BYTE;
        @(posedge clk_i);
        #2 instr_i = 8'h00;
    endtask

    task automatic run_cycles();
        repeat (100) @(posedge clk_i);                  // far past pipeline depth
    endtask

    task automatic read_byte(logic sel, reg_addr_t addr, logic [1:0] b, output byte_t val);
        @(posedge clk_i);
        #2 data_or_reg_i = sel;
        address_i   = addr;
        vout_addr_i = b;
        @(negedge clk_i);
        val = value_o;
    endtask

    task automatic read_reg(reg_addr_t addr, output word_t w);
        for (int b = 0; b < 4; b++) begin
            read_byte(1'b1, addr, b[1:0], w[8*b +: 8]);
        end
    endtask

    task automatic read_mem(dmem_addr_t addr, output word_t w);
        for (int b = 0; b < 4; b++) begin
            read_byte(1'b0, addr, b[1:0], w[8*b +: 8]);
        end
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected 0x%08h, got 0x%08h", name, expected, actual);
        end
    endtask

    task automatic check_byte(string name, byte_t expected, byte_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected 0x%02h, got 0x%02h", name, expected, actual);
        end
    endtask

    // every register and data word against the model
    task automatic verify_state(string tag);
        word_t w;
        for (int i = 0; i < `NUM_REGS; i++) begin
            read_reg(reg_addr_t'(i), w);
            check_word($sformatf("%s x%0d", tag, i), model_regs[i], w);
        end
        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            read_mem(dmem_addr_t'(i), w);
            check_word($sformatf("%s dmem[%0d]", tag, i), model_mem[i], w);
        end
    endtask

    task automatic test_reset_state();
        apply_reset();
        new_program();
        verify_state("reset");
        emit_addi(0, 0, 12'd5);
        emit_addi(1, 0, 12'd3);
        emit_r(`ALU_ADD, 0, 1, 1);
        emit_end();
        load_program();
        run_cycles();
        verify_state("x0 write");
    endtask

    task automatic test_arith_chain();
        apply_reset();
        new_program();
        emit_addi(1, 0, 12'd100);
        emit_addi(2, 1, 12'd23);                        // EX/MEM source
        emit_r(`ALU_ADD, 3, 1, 2);                      // both paths
        emit_r(`ALU_SUB, 4, 3, 1);
        emit_r(`ALU_AND, 5, 4, 3);
        emit_r(`ALU_OR, 6, 5, 2);
        emit_addi(7, 6, 12'h7f0);
        emit_r(`ALU_SUB, 8, 1, 7);                      // negative result
        emit_end();
        load_program();
        run_cycles();
        verify_state("chain");
    endtask

    task automatic test_load_use();
        apply_reset();
        new_program();
        emit_addi(1, 0, 12'h123);
        emit_addi(2, 0, 12'h020);
        emit_sw(1, 2, 12'd8);
        emit_lw(3, 2, 12'd8);
        emit_r(`ALU_ADD, 4, 3, 1);                      // needs the stall
        emit_end();
        load_program();
        run_cycles();
        verify_state("load-use");
    endtask

    task automatic test_branches();
        apply_reset();
        new_program();
        emit_addi(1, 0, 12'd7);
        emit_addi(2, 0, 12'd7);
        emit_addi(3, 0, 12'd9);
        emit_addi(0, 0, 12'd0);
        emit_addi(0, 0, 12'd0);                         // operands settle in the regfile
        prog.push_back(enc_b(13'd8, 1, 2));             // taken
        prog.push_back(enc_i(12'd1, 0, 3'b000, 4, `OPC_ITYPE));   // skipped so left out of model
        prog.push_back(enc_b(13'd8, 1, 3));             // not taken
        emit_addi(5, 0, 12'd2);
        emit_end();
        load_program();
        run_cycles();
        verify_state("branch");
    endtask

    task automatic test_byte_select();
        byte_t v;
        apply_reset();
        new_program();
        emit_addi(1, 0, 12'h5a7);
        repeat (20) emit_r(`ALU_ADD, 1, 1, 1);         // shift left by doubling
        emit_addi(1, 1, 12'h6e9);
        emit_sw(1, 0, 12'd12);
        emit_end();
        load_program();
        run_cycles();
        for (int b = 0; b < 4; b++) begin
            read_byte(1'b1, 5'd1, b[1:0], v);
            check_byte($sformatf("value_o x1 byte %0d", b), model_regs[1][8*b +: 8], v);
            read_byte(1'b0, 5'd3, b[1:0], v);
            check_byte($sformatf("value_o dmem[3] byte %0d", b), model_mem[3][8*b +: 8], v);
        end
        verify_state("bytes");
    endtask

    task automatic test_second_program();
        apply_reset();
        new_program();
        emit_addi(5, 0, 12'h055);
        emit_sw(5, 0, 12'd16);
        emit_end();
        load_program();
        run_cycles();
        verify_state("first");
        apply_reset();
        new_program();                                  // only this program is expected
        emit_addi(6, 0, 12'h066);
        emit_end();
        load_program();
        run_cycles();
        verify_state("second");
    endtask

    initial begin
        test_reset_state();
        test_arith_chain();
        test_load_use();
        test_branches();
        test_byte_select();
        test_second_program();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
source/rv_core_pkg.sv
source/instr_loader.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/rv_core.sv
sim/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - include
    files:
      - source/rv_core_pkg.sv
      - source/instr_loader.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/memory_stage.sv
      - source/rv_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/rv_core_tb.sv
